/* logic/branch_unit.sv */
`timescale 1ns/10ps

module branch_unit (
    input  pipe_pkg::decode_ctl_t ctl,
    input  isa_pkg::word_t        pc,
    input  isa_pkg::word_t        inst,
    input  isa_pkg::word_t        rs_value,
    input  isa_pkg::word_t        rt_value,
    input  logic                  held_valid,
    input  logic                  ds_valid_out,
    output pipe_pkg::branch_req_t branch_req
);

    isa_pkg::word_t pc_plus4;
    isa_pkg::word_t br_offset;
    logic rs_eq_rt;
    logic rs_ltz;
    logic rs_gtz;
    logic cond_br;
    logic cond_met;

    assign pc_plus4  = pc + isa_pkg::word_t'(4);
    assign br_offset = {{14{inst[15]}}, inst[15:0], 2'b00};

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ltz   = rs_value[31];
    assign rs_gtz   = !rs_ltz && (rs_value != '0);

    assign cond_br = ctl.br_beq | ctl.br_bne | ctl.br_bgez | ctl.br_bgtz
                   | ctl.br_blez | ctl.br_bltz;

    assign cond_met = (ctl.br_beq  &&  rs_eq_rt)
                   || (ctl.br_bne  && !rs_eq_rt)
                   || (ctl.br_bgez && !rs_ltz)
                   || (ctl.br_bgtz &&  rs_gtz)
                   || (ctl.br_blez && !rs_gtz)
                   || (ctl.br_bltz &&  rs_ltz)
                   || ctl.jump_reg
                   || ctl.jump_idx;

    assign branch_req.br     = held_valid && ctl.is_branch;
    // only redirect once the operands are final
    assign branch_req.taken  = cond_met && ds_valid_out;
    assign branch_req.target = cond_br      ? pc_plus4 + br_offset :
                               ctl.jump_reg ? rs_value :
                                              {pc_plus4[31:28], inst[25:0], 2'b00};

endmodule

/* logic/decode_config.svh */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// register, pc and instruction width
`define DATA_WIDTH 32

`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// one-hot ALU operation vector
`define ALU_OP_WIDTH 12

`endif

/* logic/decode_ctrl.sv */
`timescale 1ns/10ps

module decode_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fs_valid,
    input  pipe_pkg::fetch_pkt_t fetch_pkt,
    input  logic                 es_allowin,
    input  logic                 hazard,
    output logic                 ds_allowin,
    output logic                 ds_valid,
    output logic                 ds_valid_out,
    output pipe_pkg::fetch_pkt_t held_pkt
);

    logic ready_go;

    assign ready_go     = ~hazard;
    assign ds_allowin   = ~ds_valid | (ready_go & es_allowin);
    assign ds_valid_out = ds_valid & ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    // packet only moves on a real handoff
    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            held_pkt <= fetch_pkt;
        end
    end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_valid,
    input  pipe_pkg::fetch_pkt_t  fetch_pkt,
    output logic                  ds_allowin,
    input  logic                  es_allowin,
    output logic                  ds_valid_out,
    output pipe_pkg::decode_pkt_t decode_pkt,
    output pipe_pkg::branch_req_t branch_req,
    input  pipe_pkg::rf_write_t   rf_wr,
    input  pipe_pkg::bypass_src_t fwd_es,
    input  pipe_pkg::bypass_src_t fwd_ms,
    input  pipe_pkg::bypass_src_t fwd_ws
);

    pipe_pkg::fetch_pkt_t  held_pkt;
    pipe_pkg::decode_ctl_t ctl;
    isa_pkg::reg_addr_t    dest;
    isa_pkg::imm16_t       imm;
    isa_pkg::reg_addr_t    rs;
    isa_pkg::reg_addr_t    rt;
    isa_pkg::word_t        rf_rs;
    isa_pkg::word_t        rf_rt;
    isa_pkg::word_t        rs_value;
    isa_pkg::word_t        rt_value;
    logic                  hazard;
    logic                  ds_valid;

    decode_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .fs_valid     (fs_valid),
        .fetch_pkt    (fetch_pkt),
        .es_allowin   (es_allowin),
        .hazard       (hazard),
        .ds_allowin   (ds_allowin),
        .ds_valid     (ds_valid),
        .ds_valid_out (ds_valid_out),
        .held_pkt     (held_pkt)
    );

    inst_decoder u_decoder (
        .inst (held_pkt.inst),
        .ctl  (ctl),
        .dest (dest),
        .imm  (imm),
        .rs   (rs),
        .rt   (rt)
    );

    gpr_file u_gpr (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt),
        .wr     (rf_wr)
    );

    operand_bypass u_bypass (
        .rs       (rs),
        .rt       (rt),
        .reads_rs (ctl.reads_rs),
        .reads_rt (ctl.reads_rt),
        .rf_rs    (rf_rs),
        .rf_rt    (rf_rt),
        .fwd_es   (fwd_es),
        .fwd_ms   (fwd_ms),
        .fwd_ws   (fwd_ws),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .hazard   (hazard)
    );

    branch_unit u_branch (
        .ctl          (ctl),
        .pc           (held_pkt.pc),
        .inst         (held_pkt.inst),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .held_valid   (ds_valid),
        .ds_valid_out (ds_valid_out),
        .branch_req   (branch_req)
    );

    always_comb begin
        decode_pkt.alu_op           = ctl.alu_op;
        decode_pkt.load_word        = ctl.load_word;
        decode_pkt.mem_we           = ctl.mem_we;
        decode_pkt.gr_we            = ctl.gr_we;
        decode_pkt.src1_is_sa       = ctl.src1_is_sa;
        decode_pkt.src1_is_pc       = ctl.src1_is_pc;
        decode_pkt.src2_is_imm      = ctl.src2_is_imm;
        decode_pkt.src2_is_zext_imm = ctl.src2_is_zext_imm;
        decode_pkt.src2_is_8        = ctl.src2_is_8;
        decode_pkt.dest             = dest;
        decode_pkt.imm              = imm;
        decode_pkt.rs_value         = rs_value;
        decode_pkt.rt_value         = rt_value;
        decode_pkt.pc               = held_pkt.pc;
    end

endmodule

/* logic/gpr_file.sv */
`timescale 1ns/10ps
`include "decode_config.svh"

module gpr_file (
    input  logic                clk,
    input  logic                reset,
    input  isa_pkg::reg_addr_t  raddr1,
    input  isa_pkg::reg_addr_t  raddr2,
    output isa_pkg::word_t      rdata1,
    output isa_pkg::word_t      rdata2,
    input  pipe_pkg::rf_write_t wr
);

    isa_pkg::word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 reads zero and a write shows only after the edge
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* logic/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder (
    input  isa_pkg::word_t       inst,
    output pipe_pkg::decode_ctl_t ctl,
    output isa_pkg::reg_addr_t   dest,
    output isa_pkg::imm16_t      imm,
    output isa_pkg::reg_addr_t   rs,
    output isa_pkg::reg_addr_t   rt
);

    logic [5:0] op;
    logic [5:0] funct;
    isa_pkg::reg_addr_t rd;
    isa_pkg::reg_addr_t sa;
    logic special;
    logic r_alu;
    logic r_shift;
    logic inst_addu, inst_subu, inst_slt, inst_sltu, inst_and, inst_or;
    logic inst_xor, inst_nor, inst_sll, inst_srl, inst_sra, inst_jr;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw, inst_beq, inst_bne, inst_bgez, inst_bgtz;
    logic inst_blez, inst_bltz, inst_j, inst_jal;
    logic dst_is_rt;

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign sa    = inst[10:6];
    assign funct = inst[5:0];
    assign imm   = inst[15:0];

    assign special = (op == isa_pkg::OP_SPECIAL);
    // three-register forms leave sa zero, shifts leave rs zero
    assign r_alu   = special && (sa == '0);
    assign r_shift = special && (rs == '0);

    assign inst_addu  = r_alu && (funct == isa_pkg::FN_ADDU);
    assign inst_subu  = r_alu && (funct == isa_pkg::FN_SUBU);
    assign inst_slt   = r_alu && (funct == isa_pkg::FN_SLT);
    assign inst_sltu  = r_alu && (funct == isa_pkg::FN_SLTU);
    assign inst_and   = r_alu && (funct == isa_pkg::FN_AND);
    assign inst_or    = r_alu && (funct == isa_pkg::FN_OR);
    assign inst_xor   = r_alu && (funct == isa_pkg::FN_XOR);
    assign inst_nor   = r_alu && (funct == isa_pkg::FN_NOR);
    assign inst_sll   = r_shift && (funct == isa_pkg::FN_SLL);
    assign inst_srl   = r_shift && (funct == isa_pkg::FN_SRL);
    assign inst_sra   = r_shift && (funct == isa_pkg::FN_SRA);
    assign inst_jr    = r_alu && (funct == isa_pkg::FN_JR) && (rt == '0) && (rd == '0);
    assign inst_addiu = (op == isa_pkg::OP_ADDIU);
    assign inst_slti  = (op == isa_pkg::OP_SLTI);
    assign inst_sltiu = (op == isa_pkg::OP_SLTIU);
    assign inst_andi  = (op == isa_pkg::OP_ANDI);
    assign inst_ori   = (op == isa_pkg::OP_ORI);
    assign inst_xori  = (op == isa_pkg::OP_XORI);
    assign inst_lui   = (op == isa_pkg::OP_LUI) && (rs == '0);
    assign inst_lw    = (op == isa_pkg::OP_LW);
    assign inst_sw    = (op == isa_pkg::OP_SW);
    assign inst_beq   = (op == isa_pkg::OP_BEQ);
    assign inst_bne   = (op == isa_pkg::OP_BNE);
    assign inst_bgez  = (op == isa_pkg::OP_REGIMM) && (rt == isa_pkg::RT_BGEZ);
    assign inst_bltz  = (op == isa_pkg::OP_REGIMM) && (rt == isa_pkg::RT_BLTZ);
    assign inst_bgtz  = (op == isa_pkg::OP_BGTZ) && (rt == '0);
    assign inst_blez  = (op == isa_pkg::OP_BLEZ) && (rt == '0);
    assign inst_j     = (op == isa_pkg::OP_J);
    assign inst_jal   = (op == isa_pkg::OP_JAL);

    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                     | inst_xori | inst_lui | inst_lw;

    assign dest = inst_jal  ? isa_pkg::reg_addr_t'(31) :
                  dst_is_rt ? rt :
                              rd;

    always_comb begin
        ctl = '0;
        ctl.alu_op[isa_pkg::ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
        ctl.alu_op[isa_pkg::ALU_SUB]  = inst_subu;
        ctl.alu_op[isa_pkg::ALU_SLT]  = inst_slt | inst_slti;
        ctl.alu_op[isa_pkg::ALU_SLTU] = inst_sltu | inst_sltiu;
        ctl.alu_op[isa_pkg::ALU_AND]  = inst_and | inst_andi;
        ctl.alu_op[isa_pkg::ALU_NOR]  = inst_nor;
        ctl.alu_op[isa_pkg::ALU_OR]   = inst_or | inst_ori;
        ctl.alu_op[isa_pkg::ALU_XOR]  = inst_xor | inst_xori;
        ctl.alu_op[isa_pkg::ALU_SLL]  = inst_sll;
        ctl.alu_op[isa_pkg::ALU_SRL]  = inst_srl;
        ctl.alu_op[isa_pkg::ALU_SRA]  = inst_sra;
        ctl.alu_op[isa_pkg::ALU_LUI]  = inst_lui;
        ctl.load_word        = inst_lw;
        ctl.mem_we           = inst_sw;
        // anything not listed decodes as a bubble
        ctl.gr_we            = (|ctl.alu_op) & ~inst_sw;
        ctl.src1_is_sa       = inst_sll | inst_srl | inst_sra;
        ctl.src1_is_pc       = inst_jal;
        ctl.src2_is_imm      = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
        ctl.src2_is_zext_imm = inst_andi | inst_ori | inst_xori;
        ctl.src2_is_8        = inst_jal;
        ctl.reads_rt         = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and
                             | inst_or | inst_xor | inst_nor | ctl.src1_is_sa
                             | inst_sw | inst_beq | inst_bne;
        ctl.reads_rs         = (ctl.reads_rt & ~ctl.src1_is_sa) | inst_addiu | inst_slti
                             | inst_sltiu | ctl.src2_is_zext_imm | inst_lw | inst_bgez
                             | inst_bgtz | inst_blez | inst_bltz | inst_jr;
        ctl.br_beq           = inst_beq;
        ctl.br_bne           = inst_bne;
        ctl.br_bgez          = inst_bgez;
        ctl.br_bgtz          = inst_bgtz;
        ctl.br_blez          = inst_blez;
        ctl.br_bltz          = inst_bltz;
        ctl.jump_reg         = inst_jr;
        ctl.jump_idx         = inst_j | inst_jal;
        ctl.is_branch        = inst_beq | inst_bne | inst_bgez | inst_bgtz | inst_blez
                             | inst_bltz | inst_jr | inst_j | inst_jal;
    end

endmodule

/* logic/isa_pkg.sv */
`include "decode_config.svh"

package isa_pkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [15:0] imm16_t;
    typedef logic [`ALU_OP_WIDTH-1:0] alu_op_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // regimm branches are told apart by the rt field
    localparam reg_addr_t RT_BLTZ = 5'h00;
    localparam reg_addr_t RT_BGEZ = 5'h01;

    // bit positions in alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

endpackage

/* logic/operand_bypass.sv */
`timescale 1ns/10ps

module operand_bypass (
    input  isa_pkg::reg_addr_t    rs,
    input  isa_pkg::reg_addr_t    rt,
    input  logic                  reads_rs,
    input  logic                  reads_rt,
    input  isa_pkg::word_t        rf_rs,
    input  isa_pkg::word_t        rf_rt,
    input  pipe_pkg::bypass_src_t fwd_es,
    input  pipe_pkg::bypass_src_t fwd_ms,
    input  pipe_pkg::bypass_src_t fwd_ws,
    output isa_pkg::word_t        rs_value,
    output isa_pkg::word_t        rt_value,
    output logic                  hazard
);

    logic rs_in_es, rs_in_ms, rs_in_ws;
    logic rt_in_es, rt_in_ms, rt_in_ws;

    function automatic logic src_hit(input logic reads,
                                     input isa_pkg::reg_addr_t r,
                                     input pipe_pkg::bypass_src_t src);
        return reads && (r != '0) && src.gr_we && (src.dest == r);
    endfunction

    assign rs_in_es = src_hit(reads_rs, rs, fwd_es);
    assign rs_in_ms = src_hit(reads_rs, rs, fwd_ms);
    assign rs_in_ws = src_hit(reads_rs, rs, fwd_ws);
    assign rt_in_es = src_hit(reads_rt, rt, fwd_es);
    assign rt_in_ms = src_hit(reads_rt, rt, fwd_ms);
    assign rt_in_ws = src_hit(reads_rt, rt, fwd_ws);

    // youngest producer first
    assign rs_value = rs_in_es ? fwd_es.result :
                      rs_in_ms ? fwd_ms.result :
                      rs_in_ws ? fwd_ws.result :
                                 rf_rs;
    assign rt_value = rt_in_es ? fwd_es.result :
                      rt_in_ms ? fwd_ms.result :
                      rt_in_ws ? fwd_ws.result :
                                 rf_rt;

    assign hazard = ((rs_in_es | rt_in_es) & ~fwd_es.valid)
                  | ((rs_in_ms | rt_in_ms) & ~fwd_ms.valid)
                  | ((rs_in_ws | rt_in_ws) & ~fwd_ws.valid);

endmodule

/* logic/pipe_pkg.sv */
package pipe_pkg;

    // fetch to decode
    typedef struct packed {
        isa_pkg::word_t inst;
        isa_pkg::word_t pc;
    } fetch_pkt_t;

    // write-back port of the register file
    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t addr;
        isa_pkg::word_t     data;
    } rf_write_t;

    // producer record from execute, memory or write-back
    typedef struct packed {
        logic               gr_we;
        logic               valid;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     result;
    } bypass_src_t;

    // decode to execute
    typedef struct packed {
        isa_pkg::alu_op_t   alu_op;
        logic               load_word;
        logic               mem_we;
        logic               gr_we;
        logic               src1_is_sa;
        logic               src1_is_pc;
        logic               src2_is_imm;
        logic               src2_is_zext_imm;
        logic               src2_is_8;
        isa_pkg::reg_addr_t dest;
        isa_pkg::imm16_t    imm;
        isa_pkg::word_t     rs_value;
        isa_pkg::word_t     rt_value;
        isa_pkg::word_t     pc;
    } decode_pkt_t;

    // decode to fetch
    typedef struct packed {
        logic           br;
        logic           taken;
        isa_pkg::word_t target;
    } branch_req_t;

    // control flags inside the decode stage
    typedef struct packed {
        isa_pkg::alu_op_t alu_op;
        logic             load_word;
        logic             mem_we;
        logic             gr_we;
        logic             src1_is_sa;
        logic             src1_is_pc;
        logic             src2_is_imm;
        logic             src2_is_zext_imm;
        logic             src2_is_8;
        logic             reads_rs;
        logic             reads_rt;
        logic             is_branch;
        logic             br_beq;
        logic             br_bne;
        logic             br_bgez;
        logic             br_bgtz;
        logic             br_blez;
        logic             br_bltz;
        logic             jump_reg;
        logic             jump_idx;
    } decode_ctl_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing -f verilog.f --top-module decode_stage_tb \
    -o decode_stage_sim > sim.log 2>&1 \
    && ./obj_dir/decode_stage_sim >> sim.log 2>&1 \
    || { echo "build or simulation error, see sim.log"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"

/* verif/decode_stage_tb.sv */
`timescale 1ns/10ps

module decode_stage_tb;

    localparam int WAIT_LIMIT   = 50;
    localparam int STALL_CYCLES = 4;

    logic                  clk;
    logic                  reset;
    logic                  fs_valid;
    pipe_pkg::fetch_pkt_t  fetch_pkt;
    logic                  ds_allowin;
    logic                  es_allowin;
    logic                  ds_valid_out;
    pipe_pkg::decode_pkt_t decode_pkt;
    pipe_pkg::branch_req_t branch_req;
    pipe_pkg::rf_write_t   rf_wr;
    pipe_pkg::bypass_src_t fwd_es;
    pipe_pkg::bypass_src_t fwd_ms;
    pipe_pkg::bypass_src_t fwd_ws;

    // what the register file should hold
    isa_pkg::word_t reg_model [32];
    integer seed;
    int     errors;
    int     checks;
    logic   aborted;

    decode_stage decode_stage_i (
        .clk          (clk),
        .reset        (reset),
        .fs_valid     (fs_valid),
        .fetch_pkt    (fetch_pkt),
        .ds_allowin   (ds_allowin),
        .es_allowin   (es_allowin),
        .ds_valid_out (ds_valid_out),
        .decode_pkt   (decode_pkt),
        .branch_req   (branch_req),
        .rf_wr        (rf_wr),
        .fwd_es       (fwd_es),
        .fwd_ms       (fwd_ms),
        .fwd_ws       (fwd_ws)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic check_word(input isa_pkg::word_t got, input isa_pkg::word_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg_addr(input isa_pkg::reg_addr_t got,
                                  input isa_pkg::reg_addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_alu_op(input isa_pkg::alu_op_t got, input isa_pkg::alu_op_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic wait_allowin();
        int n;
        n = 0;
        @(negedge clk);
        while (!ds_allowin && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!ds_allowin) begin
            $display("timeout: ds_allowin stayed low for %0d cycles", WAIT_LIMIT);
            aborted = 1'b1;
        end
    endtask

    task automatic wait_valid_out();
        int n;
        n = 0;
        @(negedge clk);
        while (!ds_valid_out && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!ds_valid_out) begin
            $display("timeout: ds_valid_out never rose within %0d cycles", WAIT_LIMIT);
            aborted = 1'b1;
        end
    endtask

    task automatic write_reg(input isa_pkg::reg_addr_t addr, input isa_pkg::word_t data);
        @(posedge clk);
        rf_wr.we   <= 1'b1;
        rf_wr.addr <= addr;
        rf_wr.data <= data;
        @(posedge clk);
        rf_wr.we <= 1'b0;
        // r0 stays zero
        if (addr != '0) begin
            reg_model[addr] = data;
        end
    endtask

    task automatic set_bypass(input logic [1:0] slot, input pipe_pkg::bypass_src_t rec);
        @(posedge clk);
        case (slot)
            2'd0: fwd_es <= rec;
            2'd1: fwd_ms <= rec;
            default: fwd_ws <= rec;
        endcase
    endtask

    // mode bits from lsb up are check rs, check rt, rs from model, rt from model,
    // check target and stall
    task automatic issue_inst(input isa_pkg::word_t pc, input isa_pkg::word_t inst,
                              input int hold, input isa_pkg::alu_op_t exp_alu,
                              input logic [9:0] flags, input isa_pkg::reg_addr_t exp_dest,
                              input isa_pkg::word_t exp_rs, input isa_pkg::word_t exp_rt,
                              input isa_pkg::word_t exp_target, input logic [5:0] mode);
        pipe_pkg::decode_pkt_t held;
        isa_pkg::word_t want_rs;
        isa_pkg::word_t want_rt;
        want_rs = mode[2] ? reg_model[inst[25:21]] : exp_rs;
        want_rt = mode[3] ? reg_model[inst[20:16]] : exp_rt;
        wait_allowin();
        if (!aborted) begin
            @(posedge clk);
            fs_valid       <= 1'b1;
            fetch_pkt.pc   <= pc;
            fetch_pkt.inst <= inst;
            @(posedge clk);
            fs_valid <= 1'b0;
            if (mode[5]) begin
                repeat (STALL_CYCLES) begin
                    @(negedge clk);
                    check_flag(ds_valid_out, 1'b0, "ds_valid_out while stalled");
                    check_flag(ds_allowin, 1'b0, "ds_allowin while stalled");
                end
                @(posedge clk);
                fwd_es.valid <= 1'b1;
                fwd_ms.valid <= 1'b1;
                fwd_ws.valid <= 1'b1;
            end
            wait_valid_out();
        end
        if (!aborted) begin
            check_alu_op(decode_pkt.alu_op, exp_alu, "alu_op");
            check_flag(decode_pkt.load_word, flags[0], "load_word");
            check_flag(decode_pkt.mem_we, flags[1], "mem_we");
            check_flag(decode_pkt.gr_we, flags[2], "gr_we");
            check_flag(decode_pkt.src1_is_sa, flags[3], "src1_is_sa");
            check_flag(decode_pkt.src1_is_pc, flags[4], "src1_is_pc");
            check_flag(decode_pkt.src2_is_imm, flags[5], "src2_is_imm");
            check_flag(decode_pkt.src2_is_zext_imm, flags[6], "src2_is_zext_imm");
            check_flag(decode_pkt.src2_is_8, flags[7], "src2_is_8");
            check_flag(branch_req.br, flags[8], "branch br");
            check_flag(branch_req.taken, flags[9], "branch taken");
            check_reg_addr(decode_pkt.dest, exp_dest, "dest");
            check_word({16'h0, decode_pkt.imm}, {16'h0, inst[15:0]}, "imm");
            check_word(decode_pkt.pc, pc, "pc");
            if (mode[0]) begin
                check_word(decode_pkt.rs_value, want_rs, "rs_value");
            end
            if (mode[1]) begin
                check_word(decode_pkt.rt_value, want_rt, "rt_value");
            end
            if (mode[4]) begin
                check_word(branch_req.target, exp_target, "branch target");
            end
            // execute not ready while fetch offers a different packet
            held = decode_pkt;
            if (hold > 0) begin
                @(posedge clk);
                fs_valid       <= 1'b1;
                fetch_pkt.pc   <= pc + isa_pkg::word_t'(4);
                fetch_pkt.inst <= ~inst;
            end
            repeat (hold) begin
                @(negedge clk);
                check_flag(decode_pkt == held, 1'b1, "decode_pkt steady under back-pressure");
                check_flag(ds_allowin, 1'b0, "ds_allowin under back-pressure");
            end
            @(posedge clk);
            fs_valid   <= 1'b0;
            es_allowin <= 1'b1;
            @(posedge clk);
            es_allowin <= 1'b0;
        end
    endtask

    initial begin
        int fd;
        int n;
        int steps;
        logic [31:0] op, a, b, c, d, e, f, g, h, i, j;
        pipe_pkg::bypass_src_t rec;
        seed    = 32'hc758;
        errors  = 0;
        checks  = 0;
        steps   = 0;
        aborted = 1'b0;
        for (int k = 0; k < 32; k++) begin
            reg_model[k] = '0;
        end
        reset      <= 1'b1;
        fs_valid   <= 1'b0;
        fetch_pkt  <= '0;
        es_allowin <= 1'b0;
        rf_wr      <= '0;
        fwd_es     <= '0;
        fwd_ms     <= '0;
        fwd_ws     <= '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag(ds_valid_out, 1'b0, "ds_valid_out after reset");
        check_flag(branch_req.br, 1'b0, "br after reset");
        check_flag(ds_allowin, 1'b1, "ds_allowin after reset");

        fd = $fopen("verif/decode_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/decode_testdata.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h\n",
                        op, a, b, c, d, e, f, g, h, i, j);
            if (n == 11) begin
                steps++;
                case (op)
                    1: write_reg(a[4:0], c[0] ? $random(seed) : b);
                    2: begin
                        rec.gr_we  = b[0];
                        rec.valid  = c[0];
                        rec.dest   = d[4:0];
                        rec.result = e;
                        set_bypass(a[1:0], rec);
                    end
                    3: issue_inst(a, b, int'(c), d[11:0], e[9:0], f[4:0], g, h, i, j[5:0]);
                    default: begin
                        $display("unknown step code %0h in test data", op);
                        aborted = 1'b1;
                    end
                endcase
            end else if (!$feof(fd)) begin
                $display("malformed record after step %0d in test data", steps);
                aborted = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (steps == 0 && !aborted) begin
            $display("no test steps were read from the test data");
            aborted = 1'b1;
        end

        $display("decode stage: %0d steps, %0d checks, %0d errors", steps, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verif/decode_testdata.txt */
1 01 00000000 1 0 0 0 0 0 0 0
1 02 00000000 1 0 0 0 0 0 0 0
1 03 00000000 1 0 0 0 0 0 0 0
1 04 80000000 0 0 0 0 0 0 0 0
1 06 00000010 0 0 0 0 0 0 0 0
1 07 00400100 0 0 0 0 0 0 0 0
1 00 00000000 1 0 0 0 0 0 0 0
3 00001000 00224021 3 001 004 08 00000000 00000000 00000000 0f
3 00001004 0086502a 0 004 004 0a 80000000 00000010 00000000 03
3 00001008 00024940 0 100 00c 09 00000000 00000000 00000000 0a
3 0000100c 000458c3 0 400 00c 0b 00000000 80000000 00000000 02
3 00001010 34cc8001 0 040 044 0c 00000010 00000000 00000000 01
3 00001014 242dfff0 0 001 024 0d 00000000 00000000 00000000 05
3 00001018 3c0e1234 0 800 024 0e 00000000 00000000 00000000 00
3 0000101c 8c4f0008 0 001 025 0f 00000000 00000000 00000000 05
3 00001020 ac23fffc 0 001 022 1f 00000000 00000000 00000000 0f
3 00001024 00038021 0 001 004 10 00000000 00000000 00000000 0b
3 00001028 fc000000 0 000 000 00 00000000 00000000 00000000 00
2 0 1 1 01 aaaa0001 0 0 0 0 0
2 1 1 1 01 bbbb0001 0 0 0 0 0
2 2 1 1 02 cccc0002 0 0 0 0 0
3 00001100 00224021 0 001 004 08 aaaa0001 cccc0002 00000000 03
2 0 0 1 01 aaaa0001 0 0 0 0 0
2 2 1 1 01 cccc0001 0 0 0 0 0
3 00001104 00224021 0 001 004 08 bbbb0001 00000000 00000000 0b
2 0 1 1 00 dddd0000 0 0 0 0 0
2 1 1 0 0c eeee000c 0 0 0 0 0
2 2 0 0 00 00000000 0 0 0 0 0
3 00001108 00038021 0 001 004 10 00000000 00000000 00000000 0b
3 0000110c 34cc8001 0 040 044 0c 00000010 00000000 00000000 03
2 0 1 0 02 12345678 0 0 0 0 0
2 1 0 0 00 00000000 0 0 0 0 0
3 00001110 00224021 0 001 004 08 00000000 12345678 00000000 27
2 0 0 0 00 00000000 0 0 0 0 0
3 00002000 10c60010 0 000 300 00 00000010 00000010 00002044 13
3 00002000 14c6fff0 0 000 100 1f 00000000 00000000 00001fc4 10
3 00002000 04810004 0 000 100 00 00000000 00000000 00002014 10
3 00002000 04800004 0 000 300 00 00000000 00000000 00002014 10
3 00002000 1cc00008 0 000 300 00 00000000 00000000 00002024 10
3 00002000 18000008 0 000 300 00 00000000 00000000 00002024 10
3 10002000 08100040 0 000 300 00 00000000 00000000 10400100 10
3 10002000 0c100040 2 001 394 1f 00000000 00000000 10400100 10
3 00002000 00e00008 0 000 300 00 00400100 00000000 00400100 11

/* verilog.f */
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/inst_decoder.sv
logic/gpr_file.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/decode_ctrl.sv
logic/decode_stage.sv
verif/decode_stage_tb.sv
